// File: logic/memory_pkg.sv
// L1 data cache geometry
// Way and set counts, index, tag and line widths, and the matching vector types

package memory_pkg;

  // Ways per set
  parameter int unsigned DCACHE_L1_ASSOCIATIVITY = 4;
  // Sets in the cache
  parameter int unsigned DCACHE_L1_SETS          = 8;

  // Index widths follow from the counts above
  parameter int unsigned DCACHE_SET_W            = $clog2(DCACHE_L1_SETS);
  parameter int unsigned DCACHE_WAY_W            = $clog2(DCACHE_L1_ASSOCIATIVITY);

  // Address tag kept per line
  parameter int unsigned DCACHE_TAG_W            = 20;
  // One cache line of data
  parameter int unsigned DCACHE_LINE_W           = 64;

  // One dirty bit per way, bit k is way k
  typedef logic [DCACHE_L1_ASSOCIATIVITY-1:0] dirty_vec_t;

  // Set index
  typedef logic [DCACHE_SET_W-1:0]            set_idx_t;
  // Way index, binary coded
  typedef logic [DCACHE_WAY_W-1:0]            way_idx_t;

  // Tag of a line
  typedef logic [DCACHE_TAG_W-1:0]            tag_t;
  // Data of a line
  typedef logic [DCACHE_LINE_W-1:0]           line_t;

endpackage

// File: logic/l2_update_pkg.sv
// Write-back control definitions
// Flush controller states and the write-back buffer entry

package l2_update_pkg;

  // Flush controller states
  // IDLE waits for a start pulse
  // SCAN walks the sets and pushes dirty lines
  // DONE waits for the WBB to drain
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    SCAN = 2'd1,
    DONE = 2'd2
  } l2_update_state_t;

  // One line on its way to L2
  // Tag, set and way locate the line, 89 bits in all
  typedef struct packed {
    // Tag stored with the line
    memory_pkg::tag_t     tag;
    // Set the line came from
    memory_pkg::set_idx_t set_idx;
    // Way the line came from
    memory_pkg::way_idx_t way_idx;
    // Line data
    memory_pkg::line_t    line;
  } wbb_entry_t;

endpackage

// File: logic/d1_wbb_if.sv
// Controller to write-back buffer link
// Write strobe, entry, full and empty levels with writer and buffer modports

`timescale 1ns/100ps

interface d1_wbb_if;

  // Push strobe, one entry per high cycle
  logic                      wr;
  // Line to push
  l2_update_pkg::wbb_entry_t entry;
  // No free slot, writer must hold
  logic                      full;
  // Nothing left to drain
  logic                      empty;

  // Flush controller side
  modport writer (
    output wr,
    output entry,
    input  full,
    input  empty
  );

  // Buffer side
  modport buffer (
    input  wr,
    input  entry,
    output full,
    output empty
  );

endinterface

// File: logic/d1_dirty_vec_one_hotter.sv
// Dirty vector one-hotter
// Lowest dirty way selection and the set counter enable of the flush

`timescale 1ns/100ps

module d1_dirty_vec_one_hotter (
  // Controller pushes into the WBB in this cycle
  input  logic                   l2_update_is_writing_wbb_i,
  // Dirty bits of the current set, any number set
  input  memory_pkg::dirty_vec_t mh_dirty_vec_i,
  // Only the lowest dirty way kept
  output memory_pkg::dirty_vec_t oh_dirty_vec_o,
  // Set has some dirty way
  output logic                   at_least_one_dirty_o,
  // Move the flush on to the next set
  output logic                   l2_update_cnt_en_o
);

  memory_pkg::dirty_vec_t oh_dirty_vec;
  logic                   is_clean;
  logic                   last_dirty;

  // Two's complement trick isolates the lowest set bit
  assign oh_dirty_vec = mh_dirty_vec_i & (~mh_dirty_vec_i + 1'b1);

  // No dirty way at all
  assign is_clean = (mh_dirty_vec_i == '0);

  // A single dirty way left, so the one-hot copy equals the input
  assign last_dirty = !is_clean && (mh_dirty_vec_i == oh_dirty_vec);

  assign at_least_one_dirty_o = !is_clean;

  // Clean set passes at once
  // Otherwise wait until its last dirty way goes into the WBB
  assign l2_update_cnt_en_o = is_clean || (last_dirty && l2_update_is_writing_wbb_i);

  assign oh_dirty_vec_o = oh_dirty_vec;

endmodule

// File: logic/d1_line_store.sv
// D1 line store
// Tag, data and dirty arrays with a CPU fill port and the flush read and clear port

`timescale 1ns/100ps

module d1_line_store (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  // CPU fill port, marks the line dirty
  input  logic                   cpu_wr_i,
  input  memory_pkg::set_idx_t   cpu_set_i,
  input  memory_pkg::way_idx_t   cpu_way_i,
  input  memory_pkg::tag_t       cpu_tag_i,
  input  memory_pkg::line_t      cpu_data_i,
  // Flush in progress, CPU writes are dropped
  input  logic                   busy_i,
  // Set under flush
  input  memory_pkg::set_idx_t   flush_set_i,
  // Clear the dirty bit of the selected way
  input  logic                   dirty_clr_i,
  // Selected way, one-hot
  input  memory_pkg::dirty_vec_t dirty_clr_oh_i,
  // Dirty bits of the flushed set
  output memory_pkg::dirty_vec_t dirty_vec_o,
  // Tag and data of the selected way
  output memory_pkg::tag_t       sel_tag_o,
  output memory_pkg::line_t      sel_line_o
);

  localparam int unsigned SETS = memory_pkg::DCACHE_L1_SETS;
  localparam int unsigned WAYS = memory_pkg::DCACHE_L1_ASSOCIATIVITY;

  memory_pkg::tag_t       tag_q   [SETS][WAYS];
  memory_pkg::line_t      data_q  [SETS][WAYS];
  memory_pkg::dirty_vec_t dirty_q [SETS];

  logic cpu_wr_en;

  // CPU side only acts outside a flush
  assign cpu_wr_en = cpu_wr_i && !busy_i;

  // Payload arrays
  always_ff @(posedge clk_i) begin
    if (cpu_wr_en) begin
      tag_q[cpu_set_i][cpu_way_i]  <= cpu_tag_i;
      data_q[cpu_set_i][cpu_way_i] <= cpu_data_i;
    end
  end

  // Dirty bits, set by the CPU and cleared by the flush
  // Both never act in the same cycle since busy_i gates the CPU
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int s = 0; s < SETS; s++) begin
        dirty_q[s] <= '0;
      end
    end else if (cpu_wr_en) begin
      dirty_q[cpu_set_i][cpu_way_i] <= 1'b1;
    end else if (dirty_clr_i) begin
      dirty_q[flush_set_i] <= dirty_q[flush_set_i] & ~dirty_clr_oh_i;
    end
  end

  assign dirty_vec_o = dirty_q[flush_set_i];

  // One-hot mux over the ways of the flushed set
  always_comb begin
    sel_tag_o  = '0;
    sel_line_o = '0;
    for (int k = 0; k < WAYS; k++) begin
      if (dirty_clr_oh_i[k]) begin
        sel_tag_o  = sel_tag_o | tag_q[flush_set_i][k];
        sel_line_o = sel_line_o | data_q[flush_set_i][k];
      end
    end
  end

endmodule

// File: logic/d1_l2_update.sv
// Flush controller
// Set counter, IDLE/SCAN/DONE state machine and the WBB write side

`timescale 1ns/100ps

module d1_l2_update (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  // Start pulse of a flush
  input  logic                   flush_start_i,
  // Lowest dirty way of the current set
  input  memory_pkg::dirty_vec_t oh_dirty_vec_i,
  input  logic                   at_least_one_dirty_i,
  // Set done, advance the counter
  input  logic                   cnt_en_i,
  // Line picked by the one-hot vector
  input  memory_pkg::tag_t       sel_tag_i,
  input  memory_pkg::line_t      sel_line_i,
  // Set under flush
  output memory_pkg::set_idx_t   flush_set_o,
  // Push into the WBB, also clears the dirty bit
  output logic                   writing_wbb_o,
  output logic                   busy_o,
  output logic                   done_o,
  d1_wbb_if.writer               wbb
);

  localparam memory_pkg::set_idx_t LAST_SET =
    memory_pkg::set_idx_t'(memory_pkg::DCACHE_L1_SETS - 1);

  l2_update_pkg::l2_update_state_t state_q, state_d;
  memory_pkg::set_idx_t            set_cnt_q;
  memory_pkg::way_idx_t            sel_way;
  logic                            done_q;
  logic                            writing;

  // Push a dirty line when the buffer has room
  assign writing = (state_q == l2_update_pkg::SCAN) && at_least_one_dirty_i && !wbb.full;

  // Binary way index of the one-hot pick
  always_comb begin
    sel_way = '0;
    for (int k = 0; k < memory_pkg::DCACHE_L1_ASSOCIATIVITY; k++) begin
      if (oh_dirty_vec_i[k]) begin
        sel_way = memory_pkg::way_idx_t'(k);
      end
    end
  end

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      l2_update_pkg::IDLE: begin
        if (flush_start_i) state_d = l2_update_pkg::SCAN;
      end
      l2_update_pkg::SCAN: begin
        // Last set finished
        if (cnt_en_i && set_cnt_q == LAST_SET) state_d = l2_update_pkg::DONE;
      end
      l2_update_pkg::DONE: begin
        // Wait for the last entries to reach L2
        if (wbb.empty) state_d = l2_update_pkg::IDLE;
      end
      default: state_d = l2_update_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= l2_update_pkg::IDLE;
      set_cnt_q <= '0;
      done_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      // Pulse when DONE hands back to IDLE
      done_q  <= (state_q == l2_update_pkg::DONE) && wbb.empty;
      if (state_q == l2_update_pkg::IDLE) begin
        set_cnt_q <= '0;
      end else if (state_q == l2_update_pkg::SCAN && cnt_en_i) begin
        // Wraps to zero after the last set
        set_cnt_q <= set_cnt_q + 1'b1;
      end
    end
  end

  assign flush_set_o   = set_cnt_q;
  assign writing_wbb_o = writing;
  assign busy_o        = (state_q != l2_update_pkg::IDLE);
  assign done_o        = done_q;

  // WBB write side
  assign wbb.wr            = writing;
  assign wbb.entry.tag     = sel_tag_i;
  assign wbb.entry.set_idx = set_cnt_q;
  assign wbb.entry.way_idx = sel_way;
  assign wbb.entry.line    = sel_line_i;

endmodule

// File: logic/d1_wbb.sv
// Write-back buffer
// Circular FIFO of line entries draining one per cycle to L2

`timescale 1ns/100ps

module d1_wbb #(
  parameter int unsigned WBB_DEPTH = 4
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  d1_wbb_if.buffer             wbb,
  // L2 cannot accept a write
  input  logic                 l2_busy_i,
  // Entry valid on the L2 fields
  output logic                 l2_wr_o,
  output memory_pkg::tag_t     l2_tag_o,
  output memory_pkg::set_idx_t l2_set_o,
  output memory_pkg::way_idx_t l2_way_o,
  output memory_pkg::line_t    l2_data_o
);

  // Pointer needs one bit even for a single entry
  localparam int unsigned PTR_W = (WBB_DEPTH > 1) ? $clog2(WBB_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(WBB_DEPTH + 1);

  l2_update_pkg::wbb_entry_t mem_q [WBB_DEPTH];
  l2_update_pkg::wbb_entry_t head;

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  assign push = wbb.wr;
  // Drain while L2 is free
  assign pop  = !wbb.empty && !l2_busy_i;

  assign wbb.empty = (count_q == '0);
  assign wbb.full  = (count_q == CNT_W'(WBB_DEPTH));

  // Entry storage
  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= wbb.entry;
  end

  // Pointers wrap at WBB_DEPTH, not at a power of two
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(WBB_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(WBB_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
    end
  end

  // Oldest entry straight to the L2 port
  assign head      = mem_q[rd_ptr_q];
  assign l2_wr_o   = pop;
  assign l2_tag_o  = head.tag;
  assign l2_set_o  = head.set_idx;
  assign l2_way_o  = head.way_idx;
  assign l2_data_o = head.line;

endmodule

// File: logic/d1_l2_update_top.sv
// D1 to L2 flush top level
// Line store, one-hotter, flush controller and write-back buffer

`timescale 1ns/100ps

module d1_l2_update_top #(
  parameter int unsigned WBB_DEPTH = 4
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  // CPU fill port
  input  logic                 cpu_wr_i,
  input  memory_pkg::set_idx_t cpu_set_i,
  input  memory_pkg::way_idx_t cpu_way_i,
  input  memory_pkg::tag_t     cpu_tag_i,
  input  memory_pkg::line_t    cpu_data_i,
  // Flush control
  input  logic                 flush_start_i,
  output logic                 busy_o,
  output logic                 done_o,
  // L2 write port
  output logic                 l2_wr_o,
  output memory_pkg::tag_t     l2_tag_o,
  output memory_pkg::set_idx_t l2_set_o,
  output memory_pkg::way_idx_t l2_way_o,
  output memory_pkg::line_t    l2_data_o,
  input  logic                 l2_busy_i
);

  memory_pkg::dirty_vec_t mh_dirty_vec;
  memory_pkg::dirty_vec_t oh_dirty_vec;
  memory_pkg::set_idx_t   flush_set;
  memory_pkg::tag_t       sel_tag;
  memory_pkg::line_t      sel_line;
  logic                   at_least_one_dirty;
  logic                   cnt_en;
  logic                   l2_update_is_writing_wbb;
  logic                   busy;

  d1_wbb_if wbb_if0 ();

  // Lines and dirty bits
  d1_line_store store0 (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .cpu_wr_i       (cpu_wr_i),
    .cpu_set_i      (cpu_set_i),
    .cpu_way_i      (cpu_way_i),
    .cpu_tag_i      (cpu_tag_i),
    .cpu_data_i     (cpu_data_i),
    .busy_i         (busy),
    .flush_set_i    (flush_set),
    .dirty_clr_i    (l2_update_is_writing_wbb),
    .dirty_clr_oh_i (oh_dirty_vec),
    .dirty_vec_o    (mh_dirty_vec),
    .sel_tag_o      (sel_tag),
    .sel_line_o     (sel_line)
  );

  // Lowest dirty way pick
  d1_dirty_vec_one_hotter one_hotter0 (
    .l2_update_is_writing_wbb_i (l2_update_is_writing_wbb),
    .mh_dirty_vec_i             (mh_dirty_vec),
    .oh_dirty_vec_o             (oh_dirty_vec),
    .at_least_one_dirty_o       (at_least_one_dirty),
    .l2_update_cnt_en_o         (cnt_en)
  );

  // Flush sequencing
  d1_l2_update ctrl0 (
    .clk_i                (clk_i),
    .arst_n_i             (arst_n_i),
    .flush_start_i        (flush_start_i),
    .oh_dirty_vec_i       (oh_dirty_vec),
    .at_least_one_dirty_i (at_least_one_dirty),
    .cnt_en_i             (cnt_en),
    .sel_tag_i            (sel_tag),
    .sel_line_i           (sel_line),
    .flush_set_o          (flush_set),
    .writing_wbb_o        (l2_update_is_writing_wbb),
    .busy_o               (busy),
    .done_o               (done_o),
    .wbb                  (wbb_if0.writer)
  );

  // Buffer toward L2
  d1_wbb #(
    .WBB_DEPTH (WBB_DEPTH)
  ) wbb0 (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .wbb       (wbb_if0.buffer),
    .l2_busy_i (l2_busy_i),
    .l2_wr_o   (l2_wr_o),
    .l2_tag_o  (l2_tag_o),
    .l2_set_o  (l2_set_o),
    .l2_way_o  (l2_way_o),
    .l2_data_o (l2_data_o)
  );

  assign busy_o = busy;

endmodule

// File: testbench/tb_d1_l2_update.sv
// Testbench for the D1 to L2 flush path
// Clock and reset, CPU fill stimulus, reference model of the dirty lines,
// L2 back-pressure, output assertions and a cycle timeout

`timescale 1ns/100ps

module tb_d1_l2_update;

  localparam int unsigned SETS  = memory_pkg::DCACHE_L1_SETS;
  localparam int unsigned WAYS  = memory_pkg::DCACHE_L1_ASSOCIATIVITY;
  localparam int unsigned LINES = SETS * WAYS;
  localparam int unsigned SEED  = 32'h0c859c13;

  // Test sizes
  localparam int RESET_CYCLES   = 10;
  localparam int N_WRITES       = 40;
  localparam int N_BLOCKED      = 12;
  localparam int N_FILLS        = 3;
  localparam int N_FLUSHES      = 6;
  localparam int MAX_BUSY_RUN   = 6;
  // Start, done and drain latency of one flush
  localparam int FLUSH_OVERHEAD = 8;
  localparam int FLUSH_CYCLES   = LINES + SETS + FLUSH_OVERHEAD;
  // Each write-back can sit behind one busy stretch
  localparam int BUSY_CYCLES    = MAX_BUSY_RUN * LINES;
  localparam int WORST_CYCLES   = RESET_CYCLES + N_FILLS * N_WRITES
                                + N_FLUSHES * FLUSH_CYCLES + BUSY_CYCLES;
  localparam int TIMEOUT_CYCLES = 4 * WORST_CYCLES;

  logic                 clk;
  logic                 arst_n;
  logic                 cpu_wr;
  memory_pkg::set_idx_t cpu_set;
  memory_pkg::way_idx_t cpu_way;
  memory_pkg::tag_t     cpu_tag;
  memory_pkg::line_t    cpu_data;
  logic                 flush_start;
  logic                 busy;
  logic                 done;
  logic                 l2_wr;
  memory_pkg::tag_t     l2_tag;
  memory_pkg::set_idx_t l2_set;
  memory_pkg::way_idx_t l2_way;
  memory_pkg::line_t    l2_data;
  logic                 l2_busy;

  // Reference copy of the cache contents
  memory_pkg::tag_t     ref_tag   [SETS][WAYS];
  memory_pkg::line_t    ref_data  [SETS][WAYS];
  logic                 ref_dirty [SETS][WAYS];

  // Expected write-backs appended per flush and read by the monitor
  l2_update_pkg::wbb_entry_t exp_q[$];
  int                        exp_rd;
  int                        done_count;
  int                        done_target;
  int                        cycle_cnt;
  logic                      noise_en;
  logic                      start_prev;
  logic                      busy_prev;
  string                     test_name;

  d1_l2_update_top #(
    .WBB_DEPTH (2)
  ) dut0 (
    .clk_i         (clk),
    .arst_n_i      (arst_n),
    .cpu_wr_i      (cpu_wr),
    .cpu_set_i     (cpu_set),
    .cpu_way_i     (cpu_way),
    .cpu_tag_i     (cpu_tag),
    .cpu_data_i    (cpu_data),
    .flush_start_i (flush_start),
    .busy_o        (busy),
    .done_o        (done),
    .l2_wr_o       (l2_wr),
    .l2_tag_o      (l2_tag),
    .l2_set_o      (l2_set),
    .l2_way_o      (l2_way),
    .l2_data_o     (l2_data),
    .l2_busy_i     (l2_busy)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic report_mismatch(input string field, input logic [63:0] expected,
                                 input logic [63:0] actual);
    fail_run($sformatf("[ERROR] %s: %s expected 0x%0h, actual 0x%0h",
                       test_name, field, expected, actual));
  endtask

  // Move to the drive point 10 ns after the rising edge
  task automatic step();
    @(posedge clk);
    #10;
  endtask

  // One CPU write that enters the model only when it should land
  task automatic cpu_write(input memory_pkg::set_idx_t s, input memory_pkg::way_idx_t w,
                           input memory_pkg::tag_t t, input memory_pkg::line_t d,
                           input logic lands);
    cpu_wr   = 1'b1;
    cpu_set  = s;
    cpu_way  = w;
    cpu_tag  = t;
    cpu_data = d;
    if (lands) begin
      ref_tag[s][w]   = t;
      ref_data[s][w]  = d;
      ref_dirty[s][w] = 1'b1;
    end
    step();
    cpu_wr = 1'b0;
  endtask

  task automatic random_write(input logic lands);
    memory_pkg::set_idx_t s;
    memory_pkg::way_idx_t w;
    s = memory_pkg::set_idx_t'($urandom_range(SETS - 1, 0));
    w = memory_pkg::way_idx_t'($urandom_range(WAYS - 1, 0));
    cpu_write(s, w, memory_pkg::tag_t'($urandom), {$urandom, $urandom}, lands);
  endtask

  task automatic random_fill(input int n);
    for (int i = 0; i < n; i++) begin
      random_write(1'b1);
    end
  endtask

  // Expected order is set ascending, then way ascending
  task automatic start_flush(input string name);
    l2_update_pkg::wbb_entry_t entry;
    test_name   = name;
    done_target = done_count + 1;
    for (int s = 0; s < SETS; s++) begin
      for (int w = 0; w < WAYS; w++) begin
        if (ref_dirty[s][w]) begin
          entry.tag     = ref_tag[s][w];
          entry.set_idx = memory_pkg::set_idx_t'(s);
          entry.way_idx = memory_pkg::way_idx_t'(w);
          entry.line    = ref_data[s][w];
          exp_q.push_back(entry);
          ref_dirty[s][w] = 1'b0;
        end
      end
    end
    flush_start = 1'b1;
    step();
    flush_start = 1'b0;
  endtask

  task automatic wait_done();
    while (done_count < done_target) begin
      step();
    end
  endtask

  task automatic flush_and_wait(input string name);
    start_flush(name);
    wait_done();
  endtask

  // L2 busy in random stretches while enabled
  initial begin : l2_busy_noise
    int   run_left;
    logic en;
    run_left = 0;
    l2_busy  = 1'b0;
    forever begin
      @(posedge clk);
      en = noise_en;
      #10;
      if (!en) begin
        l2_busy  = 1'b0;
        run_left = 0;
      end else begin
        if (run_left == 0) begin
          l2_busy  = 1'($urandom_range(1, 0));
          run_left = $urandom_range(MAX_BUSY_RUN, 1);
        end
        run_left = run_left - 1;
      end
    end
  end

  // Outputs are settled at the falling edge
  always @(negedge clk) begin : output_monitor
    l2_update_pkg::wbb_entry_t head;
    if (arst_n) begin
      if (start_prev) begin
        assert (busy) else fail_run("busy_o did not rise the cycle after flush_start_i");
      end
      if (busy && !busy_prev) begin
        assert (start_prev) else fail_run("busy_o rose without a flush_start_i pulse");
      end
      if (busy_prev && !done) begin
        assert (busy) else fail_run("busy_o fell before done_o");
      end
      if (l2_wr) begin
        assert (exp_rd < exp_q.size())
          else fail_run("L2 write-back seen with none left to expect");
        if (exp_rd < exp_q.size()) begin
          head   = exp_q[exp_rd];
          exp_rd = exp_rd + 1;
          assert (l2_set == head.set_idx)
            else report_mismatch("l2_set_o", 64'(head.set_idx), 64'(l2_set));
          assert (l2_way == head.way_idx)
            else report_mismatch("l2_way_o", 64'(head.way_idx), 64'(l2_way));
          assert (l2_tag == head.tag)
            else report_mismatch("l2_tag_o", 64'(head.tag), 64'(l2_tag));
          assert (l2_data == head.line)
            else report_mismatch("l2_data_o", head.line, l2_data);
        end
      end
      if (done) begin
        // Every expected line went out before done_o
        assert (exp_rd == exp_q.size())
          else report_mismatch("write-backs at done_o", 64'(exp_q.size()), 64'(exp_rd));
        done_count = done_count + 1;
      end
    end
    start_prev = flush_start;
    busy_prev  = busy;
  end

  a_l2_quiet_when_busy: assert property (@(negedge clk) disable iff (!arst_n) l2_busy |-> !l2_wr)
    else fail_run("l2_wr_o was high while l2_busy_i was high");

  a_done_drops_busy: assert property (@(negedge clk) disable iff (!arst_n) done |-> !busy)
    else fail_run("busy_o was still high in the done_o cycle");

  a_reset_outputs: assert property (@(negedge clk) !arst_n |-> (!busy && !done && !l2_wr))
    else fail_run("busy_o, done_o or l2_wr_o high during reset");

  always @(posedge clk) begin : timeout_counter
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) fail_run("Timeout, the run did not finish in time");
  end

  initial begin : main_sequence
    int k;
    void'($urandom(SEED));
    arst_n      = 1'b0;
    cpu_wr      = 1'b0;
    cpu_set     = '0;
    cpu_way     = '0;
    cpu_tag     = '0;
    cpu_data    = '0;
    flush_start = 1'b0;
    noise_en    = 1'b0;
    exp_rd      = 0;
    done_count  = 0;
    done_target = 0;
    cycle_cnt   = 0;
    start_prev  = 1'b0;
    busy_prev   = 1'b0;
    test_name   = "after_reset";
    for (int s = 0; s < SETS; s++) begin
      for (int w = 0; w < WAYS; w++) begin
        ref_dirty[s][w] = 1'b0;
      end
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #10;
    arst_n = 1'b1;
    step();
    assert (!busy && !done && !l2_wr) else fail_run("Outputs not low after reset");

    // Clean cache gives done_o and nothing for L2
    flush_and_wait("clean_flush");

    random_fill(N_WRITES);
    flush_and_wait("random_flush");

    // Every dirty bit was cleared by the previous flush
    flush_and_wait("reflush");

    random_fill(N_WRITES);
    noise_en = 1'b1;
    flush_and_wait("l2_backpressure");
    noise_en = 1'b0;
    step();
    step();

    // CPU writes during the flush must be dropped
    random_fill(N_WRITES);
    start_flush("writes_during_flush");
    k = 0;
    while (busy && k < N_BLOCKED) begin
      random_write(1'b0);
      k = k + 1;
    end
    wait_done();
    flush_and_wait("flush_after_blocked_writes");

    $display("All tests passed!");
    $finish;
  end

endmodule

// File: d1_l2_update.f
logic/memory_pkg.sv
logic/l2_update_pkg.sv
logic/d1_wbb_if.sv
logic/d1_dirty_vec_one_hotter.sv
logic/d1_line_store.sv
logic/d1_l2_update.sv
logic/d1_wbb.sv
logic/d1_l2_update_top.sv
testbench/tb_d1_l2_update.sv

// File: run_sim.sh
#!/bin/sh
# Compiles the D1 flush testbench with Verilator and runs it.
# The exit status is the simulator's, so a failing run returns nonzero.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --timescale 1ns/100ps \
  --top-module tb_d1_l2_update \
  -Mdir obj_dir \
  -f d1_l2_update.f
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit $build_status
fi

./obj_dir/Vtb_d1_l2_update
sim_status=$?
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit $sim_status
fi

echo "Simulation exited with status 0"
exit 0
